/* program.hex */
// one 32-bit instruction word per line in hex, word 0 at address 0
// trailing text after each word is the assembly it encodes
FF900093 // addi x1, x0, -7
00500113 // addi x2, x0, 5
002081B3 // add  x3, x1, x2
00302023 // sw   x3, 0(x0)
40208233 // sub  x4, x1, x2
00402223 // sw   x4, 4(x0)
0020F1B3 // and  x3, x1, x2
00302423 // sw   x3, 8(x0)
0020E1B3 // or   x3, x1, x2
00302623 // sw   x3, 12(x0)
0020C1B3 // xor  x3, x1, x2
00302823 // sw   x3, 16(x0)
0020A1B3 // slt  x3, x1, x2
00112233 // slt  x4, x2, x1
00302A23 // sw   x3, 20(x0)
00402C23 // sw   x4, 24(x0)
03002303 // lw   x6, 48(x0)
03402383 // lw   x7, 52(x0)
00730433 // add  x8, x6, x7
00802E23 // sw   x8, 28(x0)
407304B3 // sub  x9, x6, x7
02902023 // sw   x9, 32(x0)
00300513 // addi x10, x0, 3
02400593 // addi x11, x0, 36
00A5A023 // loop: sw x10, 0(x11)
00458593 // addi x11, x11, 4
FFF50513 // addi x10, x10, -1
FE051AE3 // bne  x10, x0, loop
00208463 // beq  x1, x2, +8 (not taken)
02202823 // sw   x2, 48(x0)
00050463 // beq  x10, x0, +8 (taken)
02102A23 // sw   x1, 52(x0) (skipped)
008002EF // jal  x5, +8
02102C23 // sw   x1, 56(x0) (skipped)
02502C23 // sw   x5, 56(x0)
0000006F // jal  x0, 0 (halt)

/* list.f */
rv_isa_pkg.sv
core_ctrl_pkg.sv
alu.sv
reg_file.sv
mem_port.sv
control_unit.sv
rv_core.sv
rv_core_assertions.sv
tb_rv_core.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module tb_rv_core -o tb_rv_core

run: compile
	./obj_dir/tb_rv_core > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;
    import core_ctrl_pkg::*;

    localparam int imem_words = 64;
    localparam int data_words = 16;

    logic     clk;
    logic     rst_n = 1'b1;
    mem_req_t mem_out;
    mem_rsp_t mem_in = '0;
    logic     halted;

    int          seed;
    // starting data image and ack delay per request
    logic [31:0] init_mem [data_words];
    int          delay_tab [64];

    // memory model state
    logic [31:0] data_mem [data_words];
    int          waited;
    logic [5:0]  req_cnt;
    logic        obs_valid = 1'b0;
    logic [31:0] obs_addr;
    logic [31:0] obs_data;

    // reference results
    logic [31:0] prog_rom [imem_words];
    logic [31:0] ref_mem [data_words];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_pc [$];
    bit          ref_halted;

    int store_idx = 0;
    int store_errors = 0;
    int run_errors;
    int assert_fails;
    int cycles;

    rv_core #(
        .IMEM_WORDS (imem_words)
    ) rv_core_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_out (mem_out),
        .mem_in  (mem_in),
        .halted  (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction-set model of the program, fills the expected store list
    function automatic bit run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [4:0]  rd;
        bit          stop;
        int          steps;
        for (int i = 0; i < imem_words; i++) begin
            prog_rom[i] = 32'h0;
        end
        $readmemh("program.hex", prog_rom);
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        for (int i = 0; i < data_words; i++) begin
            ref_mem[i] = init_mem[i];
        end
        pc    = 32'h0;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 2000) begin
            ins = prog_rom[pc[7:2]];
            a   = regs[ins[19:15]];
            b   = regs[ins[24:20]];
            rd  = ins[11:7];
            case (ins[6:0])
                // register-register arithmetic
                7'b0110011: begin
                    case (ins[14:12])
                        3'b000:  regs[rd] = ins[30] ? a - b : a + b;
                        3'b010:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  regs[rd] = a ^ b;
                        3'b110:  regs[rd] = a | b;
                        3'b111:  regs[rd] = a & b;
                        default: regs[rd] = a + b;
                    endcase
                    pc = pc + 32'd4;
                end
                // addi
                7'b0010011: begin
                    imm      = {{20{ins[31]}}, ins[31:20]};
                    regs[rd] = a + imm;
                    pc       = pc + 32'd4;
                end
                7'b0000011: begin
                    imm      = {{20{ins[31]}}, ins[31:20]};
                    addr     = a + imm;
                    regs[rd] = ref_mem[addr[5:2]];
                    pc       = pc + 32'd4;
                end
                7'b0100011: begin
                    imm  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    addr = a + imm;
                    ref_mem[addr[5:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    exp_pc.push_back(pc);
                    pc = pc + 32'd4;
                end
                7'b1100011: begin
                    imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                        pc = pc + imm;
                    end else begin
                        pc = pc + 32'd4;
                    end
                end
                7'b1101111: begin
                    imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                    // jump onto itself ends the program
                    if (imm == 32'h0) begin
                        stop = 1'b1;
                    end else begin
                        regs[rd] = pc + 32'd4;
                        pc       = pc + imm;
                    end
                end
                default: pc = pc + 32'd4;
            endcase
            regs[0] = 32'h0;
            steps++;
        end
        return stop;
    endfunction

    // program section a store belongs to
    function automatic string test_name(input logic [31:0] pc);
        if (pc < 32'h40) begin
            return "alu_ops";
        end else if (pc < 32'h58) begin
            return "load_delay";
        end else if (pc < 32'h80) begin
            return "branch";
        end
        return "jal_link";
    endfunction

    // four-phase slave with random ack delay
    always @(posedge clk) begin
        obs_valid <= 1'b0;
        if (rst_n) begin
            mem_in  <= '0;
            waited  <= 0;
            req_cnt <= '0;
            for (int i = 0; i < data_words; i++) begin
                data_mem[i] <= init_mem[i];
            end
        end else if (mem_in.ack) begin
            // release once the core has dropped req
            if (!mem_out.req) begin
                mem_in.ack <= 1'b0;
            end
        end else if (mem_out.req) begin
            if (waited >= delay_tab[req_cnt]) begin
                mem_in.ack <= 1'b1;
                waited     <= 0;
                req_cnt    <= req_cnt + 6'd1;
                if (mem_out.we) begin
                    data_mem[mem_out.addr[5:2]] <= mem_out.wdata;
                    obs_valid <= 1'b1;
                    obs_addr  <= mem_out.addr;
                    obs_data  <= mem_out.wdata;
                end else begin
                    mem_in.rdata <= data_mem[mem_out.addr[5:2]];
                end
            end else begin
                waited <= waited + 1;
            end
        end
    end

    // each store against the next reference entry
    always @(negedge clk) begin
        if (obs_valid) begin
            $display("store %0d: [%h] <= %h", store_idx, obs_addr, obs_data);
            if (store_idx >= exp_addr.size()) begin
                $display("store %0d to %h was not expected by the reference", store_idx,
                         obs_addr);
                store_errors++;
            end else begin
                if (obs_addr !== exp_addr[store_idx]) begin
                    $display("** Error %s store %0d address: expected %h, actual %h",
                             test_name(exp_pc[store_idx]), store_idx, exp_addr[store_idx],
                             obs_addr);
                    store_errors++;
                end
                if (obs_data !== exp_data[store_idx]) begin
                    $display("** Error %s store %0d data: expected %h, actual %h",
                             test_name(exp_pc[store_idx]), store_idx, exp_data[store_idx],
                             obs_data);
                    store_errors++;
                end
            end
            store_idx++;
        end
    end

    initial begin
        run_errors = 0;
        seed = 43;
        for (int i = 0; i < data_words; i++) begin
            init_mem[i] = $random(seed);
        end
        for (int i = 0; i < 64; i++) begin
            delay_tab[i] = $unsigned($random(seed)) % 6;
        end
        ref_halted = run_reference();
        if (!ref_halted) begin
            $display("reference model never reached the halt instruction");
            run_errors++;
        end
        $display("reference expects %0d stores", exp_addr.size());

        repeat (3) @(posedge clk);
        rst_n <= 1'b0;

        // run until the halt idiom
        cycles = 0;
        while (!halted && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("core did not raise halted within %0d cycles", cycles);
            run_errors++;
        end

        // quiet bus after halt
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            if (mem_out.req) begin
                $display("bus request seen %0d cycles after halt", i);
                run_errors++;
            end
            if (!halted) begin
                $display("halted dropped %0d cycles after it was raised", i);
                run_errors++;
            end
        end

        if (store_idx != exp_addr.size()) begin
            $display("** Error store_count: expected %0d, actual %0d", exp_addr.size(),
                     store_idx);
            run_errors++;
        end
        for (int i = 0; i < data_words; i++) begin
            if (data_mem[i] !== ref_mem[i]) begin
                $display("** Error final_memory word %0d: expected %h, actual %h", i,
                         ref_mem[i], data_mem[i]);
                run_errors++;
            end
        end

        assert_fails = rv_core_i.mem_port_i.bus_checks_i.stable_fails
                     + rv_core_i.mem_port_i.bus_checks_i.early_fails
                     + rv_core_i.mem_port_i.bus_checks_i.reset_fails;

        $display("store errors %0d, end-of-run errors %0d, assertion failures %0d",
                 store_errors, run_errors, assert_fails);
        if (store_errors + run_errors + assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* rv_core_assertions.sv */
`timescale 1ns/1ns

module rv_core_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input core_ctrl_pkg::mem_req_t bus_out,
    input core_ctrl_pkg::mem_rsp_t bus_in
);

    // one counter per check, read by the testbench at the end
    int stable_fails = 0;
    int early_fails  = 0;
    int reset_fails  = 0;

    // address, direction and data frozen while req is held
    req_stable: assert property (@(posedge clk) disable iff (rst_n)
        bus_out.req && $past(bus_out.req) |->
            $stable(bus_out.we) && $stable(bus_out.addr) && $stable(bus_out.wdata))
    else begin
        stable_fails++;
        $error("request fields changed while req was high");
    end

    // a new request only once the last ack is gone
    req_after_release: assert property (@(posedge clk) disable iff (rst_n)
        $rose(bus_out.req) |-> !bus_in.ack)
    else begin
        early_fails++;
        $error("req raised while ack was still high");
    end

    // bus idle as reset lets go
    req_idle_at_reset: assert property (@(posedge clk) $fell(rst_n) |-> !bus_out.req)
    else begin
        reset_fails++;
        $error("req high when reset was released");
    end

endmodule

// checks ride along with every mem_port
bind mem_port rv_core_assertions bus_checks_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_out (bus_out),
    .bus_in  (bus_in)
);

/* rv_core.sv */
`timescale 1ns/1ns

module rv_core #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output core_ctrl_pkg::mem_req_t mem_out,
    input  core_ctrl_pkg::mem_rsp_t mem_in,
    output logic                    halted
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int imem_aw = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;
    instr_u      ir;
    ctrl_t       ctrl;

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;

    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic        alu_less;
    logic [31:0] wb_data;
    logic        mem_done;
    logic [31:0] mem_rdata;

    // program image
    initial begin
        $readmemh("program.hex", imem);
    end

    // pc, reset to word 0
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            pc <= 32'd0;
        end else if (ctrl.pc_load) begin
            pc <= pc_next;
        end
    end

    // instruction register, loaded in fetch
    always_ff @(posedge clk) begin
        if (ctrl.ir_load) begin
            ir <= imem[pc[imem_aw+1:2]];
        end
    end

    // sign-extended immediates per format
    assign imm_i = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
    assign imm_s = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
    assign imm_b = {{19{ir.b_fmt.imm_12}}, ir.b_fmt.imm_12, ir.b_fmt.imm_11,
                    ir.b_fmt.imm_10_5, ir.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{11{ir.j_fmt.imm_20}}, ir.j_fmt.imm_20, ir.j_fmt.imm_19_12,
                    ir.j_fmt.imm_11, ir.j_fmt.imm_10_1, 1'b0};

    // operand b, store offset differs from the i-type one
    always_comb begin
        if (!ctrl.alu_src) begin
            alu_b = rs2_data;
        end else if (ir.s_fmt.opcode == opc_store) begin
            alu_b = imm_s;
        end else begin
            alu_b = imm_i;
        end
    end

    // next pc, target offset depends on branch or jal
    assign pc_plus4 = pc + 32'd4;
    assign pc_next  = !ctrl.pc_src ? pc_plus4 :
                      (ir.j_fmt.opcode == opc_jal) ? pc + imm_j : pc + imm_b;

    // writeback source
    assign wb_data = ctrl.link   ? pc_plus4  :
                     ctrl.rf_src ? mem_rdata : alu_result;

    control_unit control_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (ir),
        .zero   (alu_zero),
        .less   (alu_less),
        .done   (mem_done),
        .ctrl   (ctrl),
        .halted (halted)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (ir.r_fmt.rs1),
        .rs2    (ir.r_fmt.rs2),
        .rd     (ir.r_fmt.rd),
        .we     (ctrl.rf_we),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu alu_i (
        .a      (rs1_data),
        .b      (alu_b),
        .cmd    (ctrl.alu_cmd),
        .result (alu_result),
        .zero   (alu_zero),
        .less   (alu_less)
    );

    // address from the alu, store data straight from rs2
    mem_port mem_port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (ctrl.mem_start),
        .we      (ctrl.mem_we),
        .addr    (alu_result),
        .wdata   (rs2_data),
        .done    (mem_done),
        .rdata   (mem_rdata),
        .bus_out (mem_out),
        .bus_in  (mem_in)
    );

endmodule

/* control_unit.sv */
`timescale 1ns/1ns

module control_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::instr_u   instr,
    input  logic                 zero,
    input  logic                 less,
    input  logic                 done,
    output core_ctrl_pkg::ctrl_t ctrl,
    output logic                 halted
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    state_e state;
    state_e state_nxt;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       jal_self;
    logic       take;

    // funct3 to alu command, shared by op and op_imm
    function automatic alu_cmd_e arith_cmd(input logic [2:0] f3, input logic sub);
        alu_cmd_e cmd;
        case (f3)
            f3_add_sub: cmd = sub ? alu_sub : alu_add;
            f3_slt:     cmd = alu_slt;
            f3_xor:     cmd = alu_xor;
            f3_or:      cmd = alu_or;
            f3_and:     cmd = alu_and;
            default:    cmd = alu_add;
        endcase
        return cmd;
    endfunction

    assign opcode    = instr.r_fmt.opcode;
    assign funct3    = instr.r_fmt.funct3;
    assign is_load   = (opcode == opc_load);
    assign is_store  = (opcode == opc_store);
    assign is_branch = (opcode == opc_branch);
    assign is_jal    = (opcode == opc_jal);

    // jal to itself is the halt idiom
    assign jal_self = is_jal && ({instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                                  instr.j_fmt.imm_11, instr.j_fmt.imm_10_1} == '0);

    // branch condition from the subtract flags
    always_comb begin
        case (funct3)
            f3_beq:  take = zero;
            f3_bne:  take = !zero;
            // signed compares come for free off the same flags
            f3_blt:  take = less;
            f3_bge:  take = !less;
            default: take = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state <= st_fetch;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_fetch:  state_nxt = st_decode;
            st_decode: state_nxt = st_exec;
            st_exec: begin
                if (is_branch) begin
                    state_nxt = st_fetch;
                end else if (is_jal) begin
                    state_nxt = jal_self ? st_halt : st_fetch;
                end else if (is_load || is_store) begin
                    state_nxt = st_mem;
                end else begin
                    // alu types and unknown opcodes
                    state_nxt = st_wb;
                end
            end
            // late ack just keeps us here
            st_mem:    state_nxt = done ? st_wb : st_mem;
            st_wb:     state_nxt = st_fetch;
            st_halt:   state_nxt = st_halt;
            default:   state_nxt = st_fetch;
        endcase
    end

    // output decoder
    always_comb begin
        ctrl = '0;
        // datapath selects follow the ir in every state
        case (opcode)
            opc_op:     ctrl.alu_cmd = arith_cmd(funct3, instr.r_fmt.funct7 == f7_sub);
            opc_op_imm: ctrl.alu_cmd = arith_cmd(funct3, 1'b0);
            opc_branch: ctrl.alu_cmd = alu_sub;
            default:    ctrl.alu_cmd = alu_add;
        endcase
        ctrl.alu_src = (opcode == opc_op_imm) || is_load || is_store;
        ctrl.rf_src  = is_load;
        ctrl.link    = is_jal;

        case (state)
            st_fetch: ctrl.ir_load = 1'b1;
            st_exec: begin
                if (is_branch) begin
                    ctrl.pc_load = 1'b1;
                    ctrl.pc_src  = take;
                end else if (is_jal && !jal_self) begin
                    // jump and link in one step
                    ctrl.pc_load = 1'b1;
                    ctrl.pc_src  = 1'b1;
                    ctrl.rf_we   = 1'b1;
                end else if (is_load || is_store) begin
                    ctrl.mem_start = 1'b1;
                    ctrl.mem_we    = is_store;
                end
            end
            st_wb: begin
                ctrl.pc_load = 1'b1;
                ctrl.rf_we   = (opcode == opc_op) || (opcode == opc_op_imm) || is_load;
            end
            default: ;
        endcase
    end

    assign halted = (state == st_halt);

endmodule

/* mem_port.sv */
`timescale 1ns/1ns

module mem_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    we,
    input  logic [31:0]             addr,
    input  logic [31:0]             wdata,
    output logic                    done,
    output logic [31:0]             rdata,
    output core_ctrl_pkg::mem_req_t bus_out,
    input  core_ctrl_pkg::mem_rsp_t bus_in
);

    typedef enum logic [1:0] {
        mp_idle,
        mp_wait_ack,
        mp_wait_release
    } mp_state_e;

    mp_state_e   state;
    logic        req;
    logic        we_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;

    // four-phase handshake sequencing
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state <= mp_idle;
            req   <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                mp_idle: begin
                    if (start) begin
                        req   <= 1'b1;
                        state <= mp_wait_ack;
                    end
                end
                mp_wait_ack: begin
                    if (bus_in.ack) begin
                        req   <= 1'b0;
                        state <= mp_wait_release;
                    end
                end
                mp_wait_release: begin
                    // ack gone low, transfer complete
                    if (!bus_in.ack) begin
                        done  <= 1'b1;
                        state <= mp_idle;
                    end
                end
                default: state <= mp_idle;
            endcase
        end
    end

    // request fields frozen from start until the next start
    always_ff @(posedge clk) begin
        if ((state == mp_idle) && start) begin
            we_q    <= we;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        // load data taken while ack is high
        if ((state == mp_wait_ack) && bus_in.ack) begin
            rdata <= bus_in.rdata;
        end
    end

    assign bus_out.req   = req;
    assign bus_out.we    = we_q;
    assign bus_out.addr  = addr_q;
    assign bus_out.wdata = wdata_q;

endmodule

/* reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    // write port, x0 never written
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // combinational reads
    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu (
    input  logic                 [31:0] a,
    input  logic                 [31:0] b,
    input  rv_isa_pkg::alu_cmd_e        cmd,
    output logic                 [31:0] result,
    output logic                        zero,
    output logic                        less
);
    import rv_isa_pkg::*;

    logic [31:0] diff;
    logic        ovf;

    // one subtractor feeds sub, slt and both flags
    assign diff = a - b;

    // signed overflow of a - b
    assign ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    assign zero = (diff == 32'd0);
    // sign of the true difference
    assign less = diff[31] ^ ovf;

    always_comb begin
        case (cmd)
            alu_add: result = a + b;
            alu_sub: result = diff;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {31'd0, less};
            // unused codes fall back to add
            default: result = a + b;
        endcase
    end

endmodule

/* core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // sequencer states
    typedef enum logic [4:0] {
        st_fetch  = 5'd0,
        st_decode = 5'd1,
        st_exec   = 5'd2,
        st_mem    = 5'd3,
        st_wb     = 5'd4,
        st_halt   = 5'd5
    } state_e;

    // control word, one per cycle
    typedef struct packed {
        rv_isa_pkg::alu_cmd_e alu_cmd;
        // immediate instead of rs2
        logic alu_src;
        logic rf_we;
        // load data instead of alu result
        logic rf_src;
        // branch or jump target instead of pc+4
        logic pc_src;
        // write pc+4 back
        logic link;
        logic ir_load;
        logic pc_load;
        logic mem_start;
        logic mem_we;
    } ctrl_t;

    // data bus, core to memory
    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // data bus, memory to core
    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    // funct3 for register and immediate arithmetic
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    // funct7 picks sub over add
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // one instruction word, five ways to read it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

    // alu operation select
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5
    } alu_cmd_e;

endpackage
